//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := tbRob
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard design/*.sv testbench/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
design/robPkg.sv
design/robEntryStore.sv
design/robCommit.sv
design/robTop.sv
testbench/robCommit_chk.sv
testbench/tbRob.sv

//--- design/robCommit.sv
`timescale 1ns/1ps

module robCommit (
    input  logic                 clk,
    input  logic                 rst,
    input  robPkg::RenameUop     renUops[robPkg::Width],
    input  robPkg::BranchSquash  squash,
    input  robPkg::RobEntry      winEntries[robPkg::Width],
    input  robPkg::Flags         winFlags[robPkg::Width],
    output robPkg::RobIdx        readBase,
    output robPkg::CommitUop     comUops[robPkg::Width],
    output robPkg::TrapUop       trapUop,
    output robPkg::SqN           curSqN,
    output robPkg::SqN           maxSqN
);

    // head is the oldest live op, tail the next SqN to be renamed
    robPkg::SqN head;
    robPkg::SqN tail;
    logic stopCommit;

    robPkg::SqN slotSqN[robPkg::Width];
    logic [robPkg::Width-1:0] slotLive;
    logic [robPkg::Width-1:0] commitMask;
    logic [robPkg::Width-1:0] exceptMask;
    logic blocked;
    robPkg::SqN commitCount;

    assign readBase = head[robPkg::IdLen-1:0];
    assign curSqN = head;
    assign maxSqN = head + robPkg::SqN'(robPkg::RobSize - 1);

    // In-order retire decision over the window
    always_comb begin
        blocked = stopCommit;
        commitCount = '0;
        for (int i = 0; i < robPkg::Width; i++) begin
            slotSqN[i] = head + robPkg::SqN'(i);
            // Must be renamed and not about to be squashed
            slotLive[i] = ($signed(robPkg::SqN'(slotSqN[i] - tail)) < 0) &&
                (!squash.valid || $signed(robPkg::SqN'(slotSqN[i] - squash.sqN)) <= 0);
            commitMask[i] = !blocked && slotLive[i] && (winFlags[i] != robPkg::FlagsNx);
            exceptMask[i] = commitMask[i] && (winFlags[i] == robPkg::FlagsExcept);
            // A stalled or trapping slot holds back everything younger
            blocked = blocked || !commitMask[i] || exceptMask[i];
            commitCount = commitCount + robPkg::SqN'(commitMask[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            stopCommit <= 1'b0;
        end else begin
            head <= head + commitCount;
            // One idle commit cycle after a trap
            stopCommit <= |exceptMask;
            if (squash.valid) begin
                tail <= squash.sqN + robPkg::SqN'(1);
            end else begin
                for (int i = 0; i < robPkg::Width; i++) begin
                    if (renUops[i].valid) begin
                        tail <= renUops[i].sqN + robPkg::SqN'(1);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < robPkg::Width; i++) begin
                comUops[i] <= '0;
            end
            trapUop <= '0;
        end else begin
            for (int i = 0; i < robPkg::Width; i++) begin
                comUops[i].valid <= commitMask[i];
                comUops[i].sqN <= slotSqN[i];
                // Excepting op writes nothing to the register file
                comUops[i].rd <= exceptMask[i] ? '0 : winEntries[i].rd;
                comUops[i].tagDst <= exceptMask[i] ? robPkg::TagZero : winEntries[i].tag;
                comUops[i].compressed <= winEntries[i].compressed;
            end
            trapUop.valid <= |exceptMask;
            for (int i = 0; i < robPkg::Width; i++) begin
                if (exceptMask[i]) begin
                    trapUop.sqN <= slotSqN[i];
                    trapUop.rd <= winEntries[i].rd;
                    trapUop.tag <= winEntries[i].tag;
                end
            end
        end
    end

endmodule

//--- design/robEntryStore.sv
`timescale 1ns/1ps

module robEntryStore (
    input  logic                 clk,
    input  logic                 rst,
    input  robPkg::RenameUop     renUops[robPkg::Width],
    input  robPkg::CmplUop       cmplUops[robPkg::NumCmplPorts],
    input  robPkg::BranchSquash  squash,
    input  robPkg::RobIdx        readBase,
    output robPkg::RobEntry      winEntries[robPkg::Width],
    output robPkg::Flags         winFlags[robPkg::Width]
);

    // Entry payload is written in order by rename, flags out of order
    robPkg::RobEntry entries[robPkg::RobSize];
    robPkg::Flags flags[robPkg::RobSize];

    logic [robPkg::Width-1:0] renWrite;
    logic [robPkg::NumCmplPorts-1:0] cmplWrite;

    always_comb begin
        // Rename is dropped while a squash is in flight
        for (int i = 0; i < robPkg::Width; i++) begin
            renWrite[i] = renUops[i].valid && !squash.valid;
        end
        // Results of squashed ops must not touch the reused entries
        for (int p = 0; p < robPkg::NumCmplPorts; p++) begin
            cmplWrite[p] = cmplUops[p].valid &&
                (!squash.valid || $signed(robPkg::SqN'(cmplUops[p].sqN - squash.sqN)) <= 0);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < robPkg::Width; i++) begin
            if (renWrite[i]) begin
                entries[renUops[i].sqN[robPkg::IdLen-1:0]] <= robPkg::RobEntry'{
                    tag: renUops[i].tagDst,
                    rd: renUops[i].rd,
                    compressed: renUops[i].compressed
                };
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int e = 0; e < robPkg::RobSize; e++) begin
                flags[e] <= robPkg::FlagsNx;
            end
        end else begin
            for (int i = 0; i < robPkg::Width; i++) begin
                if (renWrite[i]) begin
                    flags[renUops[i].sqN[robPkg::IdLen-1:0]] <=
                        renUops[i].preDone ? robPkg::FlagsNone : robPkg::FlagsNx;
                end
            end
            // Completion ports never hit an entry that is being renamed
            for (int p = 0; p < robPkg::NumCmplPorts; p++) begin
                if (cmplWrite[p]) begin
                    flags[cmplUops[p].sqN[robPkg::IdLen-1:0]] <= cmplUops[p].flags;
                end
            end
        end
    end

    // Two-wide window starting at the head entry
    always_comb begin
        for (int i = 0; i < robPkg::Width; i++) begin
            winEntries[i] = entries[robPkg::RobIdx'(readBase + i)];
            winFlags[i] = flags[robPkg::RobIdx'(readBase + i)];
        end
    end

endmodule

//--- design/robPkg.sv
package robPkg;

    // Entry count is 2**IdLen
    localparam int IdLen = 4;
    localparam int RobSize = 16;
    localparam int Width = 2;
    localparam int NumCmplPorts = 2;

    // Sequence numbers wrap; age is the sign of a difference
    typedef logic [5:0] SqN;
    typedef logic [IdLen-1:0] RobIdx;
    typedef logic [6:0] Tag;
    typedef logic [4:0] RegNm;

    // Tag value for ops without a destination register
    localparam Tag TagZero = 7'h40;

    typedef enum logic [1:0] {
        FlagsNx = 2'd0,
        FlagsNone = 2'd1,
        FlagsExcept = 2'd2
    } Flags;

    typedef struct packed {
        Tag tag;
        RegNm rd;
        logic compressed;
    } RobEntry;

    typedef struct packed {
        logic valid;
        SqN sqN;
        Tag tagDst;
        RegNm rd;
        logic compressed;
        // Op is complete at rename
        logic preDone;
    } RenameUop;

    typedef struct packed {
        logic valid;
        SqN sqN;
        Flags flags;
    } CmplUop;

    // sqN is the last op that survives the squash
    typedef struct packed {
        logic valid;
        SqN sqN;
    } BranchSquash;

    typedef struct packed {
        logic valid;
        SqN sqN;
        RegNm rd;
        Tag tagDst;
        logic compressed;
    } CommitUop;

    typedef struct packed {
        logic valid;
        SqN sqN;
        RegNm rd;
        Tag tag;
    } TrapUop;

endpackage

//--- design/robTop.sv
`timescale 1ns/1ps

module robTop (
    input  logic                 clk,
    input  logic                 rst,
    input  robPkg::RenameUop     renUops[robPkg::Width],
    input  robPkg::CmplUop       cmplUops[robPkg::NumCmplPorts],
    input  robPkg::BranchSquash  squash,
    output robPkg::CommitUop     comUops[robPkg::Width],
    output robPkg::TrapUop       trapUop,
    output robPkg::SqN           curSqN,
    output robPkg::SqN           maxSqN
);

    // Window read between store and commit logic
    robPkg::RobIdx readBase;
    robPkg::RobEntry winEntries[robPkg::Width];
    robPkg::Flags winFlags[robPkg::Width];

    robEntryStore store (
        .clk        (clk),
        .rst        (rst),
        .renUops    (renUops),
        .cmplUops   (cmplUops),
        .squash     (squash),
        .readBase   (readBase),
        .winEntries (winEntries),
        .winFlags   (winFlags)
    );

    robCommit commit (
        .clk        (clk),
        .rst        (rst),
        .renUops    (renUops),
        .squash     (squash),
        .winEntries (winEntries),
        .winFlags   (winFlags),
        .readBase   (readBase),
        .comUops    (comUops),
        .trapUop    (trapUop),
        .curSqN     (curSqN),
        .maxSqN     (maxSqN)
    );

endmodule

//--- testbench/robCommit_chk.sv
`timescale 1ns/1ps

module robCommit_chk (
    input logic                clk,
    input logic                rst,
    input robPkg::CommitUop    comUops[robPkg::Width],
    input robPkg::TrapUop      trapUop,
    input robPkg::SqN          head,
    input robPkg::SqN          tail
);

    // Retire is in order across the two slots
    slotOrder: assert property (@(posedge clk) disable iff (rst)
        comUops[1].valid |-> comUops[0].valid)
        else $error("commit slot 1 valid while slot 0 is idle");

    // One idle commit cycle follows every trap
    trapPause: assert property (@(posedge clk) disable iff (rst)
        trapUop.valid |=> !comUops[0].valid && !comUops[1].valid)
        else $error("commit seen in the cycle after a trap");

    // Live entries lie between head and tail
    headBound: assert property (@(posedge clk) disable iff (rst)
        robPkg::SqN'(tail - head) <= robPkg::SqN'(robPkg::RobSize))
        else $error("head has passed the tail");

endmodule

bind robCommit robCommit_chk commitChk (
    .clk     (clk),
    .rst     (rst),
    .comUops (comUops),
    .trapUop (trapUop),
    .head    (curSqN),
    .tail    (tail)
);

//--- testbench/tbRob.sv
`timescale 1ns/1ps

module tbRob;

    logic clk;
    logic rst;
    robPkg::RenameUop renUops[robPkg::Width];
    robPkg::CmplUop cmplUops[robPkg::NumCmplPorts];
    robPkg::BranchSquash squash;
    robPkg::CommitUop comUops[robPkg::Width];
    robPkg::TrapUop trapUop;
    robPkg::SqN curSqN;
    robPkg::SqN maxSqN;

    // Model of each entry, plus the SqNs still expected to commit
    robPkg::RegNm mRd[robPkg::RobSize];
    robPkg::Tag mTag[robPkg::RobSize];
    logic mComp[robPkg::RobSize];
    logic mExc[robPkg::RobSize];
    robPkg::SqN expQ[$];
    robPkg::SqN pending[$];
    robPkg::SqN nextSqN;
    robPkg::SqN modelHead;
    logic [31:0] rngState;
    int checks;
    int errors;

    robTop uut (
        .clk      (clk),
        .rst      (rst),
        .renUops  (renUops),
        .cmplUops (cmplUops),
        .squash   (squash),
        .comUops  (comUops),
        .trapUop  (trapUop),
        .curSqN   (curSqN),
        .maxSqN   (maxSqN)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Expected commit of op s; an excepting op writes no register
    function automatic robPkg::CommitUop expectCommit(input robPkg::SqN s);
        robPkg::CommitUop c;
        robPkg::RobIdx e;
        e = s[robPkg::IdLen-1:0];
        c.valid = 1'b1;
        c.sqN = s;
        c.rd = mExc[e] ? '0 : mRd[e];
        c.tagDst = mExc[e] ? robPkg::TagZero : mTag[e];
        c.compressed = mComp[e];
        return c;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    task automatic reportError(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic finishRun();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // Renames pairs of ops from the model tail
    task automatic enqueuePairs(input int pairs, input int preDonePct);
        robPkg::RenameUop u;
        robPkg::RobIdx e;
        for (int n = 0; n < pairs; n++) begin
            @(posedge clk);
            for (int i = 0; i < robPkg::Width; i++) begin
                e = nextSqN[robPkg::IdLen-1:0];
                u.valid = 1'b1;
                u.sqN = nextSqN;
                u.tagDst = robPkg::Tag'(nextRand());
                u.rd = robPkg::RegNm'(nextRand());
                u.compressed = nextRand() % 2 == 1;
                u.preDone = (nextRand() % 100) < preDonePct;
                mRd[e] = u.rd;
                mTag[e] = u.tagDst;
                mComp[e] = u.compressed;
                mExc[e] = 1'b0;
                expQ.push_back(nextSqN);
                if (!u.preDone) begin
                    pending.push_back(nextSqN);
                end
                renUops[i] <= u;
                nextSqN = nextSqN + 1;
            end
        end
        @(posedge clk);
        for (int i = 0; i < robPkg::Width; i++) begin
            renUops[i] <= '0;
        end
    endtask

    task automatic drivePort(input int p, input robPkg::SqN s, input logic exc);
        mExc[s[robPkg::IdLen-1:0]] = exc;
        cmplUops[p] <= '{valid: 1'b1, sqN: s,
            flags: exc ? robPkg::FlagsExcept : robPkg::FlagsNone};
    endtask

    task automatic clearCmpl();
        @(posedge clk);
        for (int p = 0; p < robPkg::NumCmplPorts; p++) begin
            cmplUops[p] <= '0;
        end
    endtask

    // Completes pending ops in random order with random idle cycles
    task automatic completeAll(input int excPct);
        int pick;
        for (int guard = 0; guard < 200 && pending.size() > 0; guard++) begin
            @(posedge clk);
            for (int p = 0; p < robPkg::NumCmplPorts; p++) begin
                cmplUops[p] <= '0;
            end
            if (nextRand() % 4 != 0) begin
                for (int p = 0; p < robPkg::NumCmplPorts && pending.size() > 0; p++) begin
                    pick = int'(nextRand() % 32'(pending.size()));
                    drivePort(p, pending[pick], (nextRand() % 100) < excPct);
                    pending.delete(pick);
                end
            end
        end
        clearCmpl();
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (expQ.size() > 0 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (expQ.size() > 0) begin
            reportError("timeout while waiting for the ROB to drain");
            finishRun();
        end
    endtask

    // Squash keeps s and older; model drops everything younger
    // Caller is already on the rising edge where the squash is driven
    task automatic squashAfter(input robPkg::SqN s);
        robPkg::SqN kept[$];
        squash <= '{valid: 1'b1, sqN: s};
        @(posedge clk);
        squash <= '0;
        while (expQ.size() > 0 && $signed(robPkg::SqN'(expQ[$] - s)) > 0) begin
            expQ.pop_back();
        end
        foreach (pending[k]) begin
            if ($signed(robPkg::SqN'(pending[k] - s)) <= 0) begin
                kept.push_back(pending[k]);
            end
        end
        pending = kept;
        nextSqN = s + 1;
    endtask

    // Compare process, sampling at the falling edge
    initial begin
        robPkg::CommitUop want;
        robPkg::SqN s;
        robPkg::RobIdx e;
        logic trapSeen;
        logic pauseNext;
        pauseNext = 1'b0;
        forever begin
            @(negedge clk);
            trapSeen = 1'b0;
            if (pauseNext) begin
                checkVal("comUops[0].valid", comUops[0].valid, 1'b0);
            end
            for (int i = 0; i < robPkg::Width; i++) begin
                if (comUops[i].valid && trapSeen) begin
                    reportError("an op committed behind a trapping op in the same cycle");
                end else if (comUops[i].valid && expQ.size() == 0) begin
                    reportError("commit seen with no op outstanding");
                end else if (comUops[i].valid) begin
                    if (i > 0) begin
                        checkVal("comUops[0].valid", comUops[0].valid, 1'b1);
                    end
                    s = expQ.pop_front();
                    e = s[robPkg::IdLen-1:0];
                    want = expectCommit(s);
                    checkVal($sformatf("comUops[%0d].sqN", i), comUops[i].sqN, want.sqN);
                    checkVal($sformatf("comUops[%0d].rd", i), comUops[i].rd, want.rd);
                    checkVal($sformatf("comUops[%0d].tagDst", i), comUops[i].tagDst,
                        want.tagDst);
                    checkVal($sformatf("comUops[%0d].compressed", i), comUops[i].compressed,
                        want.compressed);
                    modelHead = s + 1;
                    if (mExc[e]) begin
                        trapSeen = 1'b1;
                        checkVal("trapUop.valid", trapUop.valid, 1'b1);
                        checkVal("trapUop.sqN", trapUop.sqN, s);
                        checkVal("trapUop.rd", trapUop.rd, mRd[e]);
                        checkVal("trapUop.tag", trapUop.tag, mTag[e]);
                    end
                end
            end
            pauseNext = trapSeen;
            if (!trapSeen) begin
                checkVal("trapUop.valid", trapUop.valid, 1'b0);
            end
            checkVal("curSqN", curSqN, modelHead);
            checkVal("maxSqN", maxSqN, robPkg::SqN'(modelHead + 6'd15));
        end
    end

    initial begin
        robPkg::SqN s;
        rngState = 32'd56;
        checks = 0;
        errors = 0;
        nextSqN = '0;
        modelHead = '0;
        rst = 1'b1;
        squash = '0;
        for (int i = 0; i < robPkg::Width; i++) begin
            renUops[i] = '0;
        end
        for (int p = 0; p < robPkg::NumCmplPorts; p++) begin
            cmplUops[p] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Random completion order, some ops done at rename, a few exceptions
        for (int r = 0; r < 12; r++) begin
            enqueuePairs(3, 25);
            completeAll(12);
            waitDrain();
        end

        // Incomplete head holds back completed younger ops
        s = nextSqN;
        enqueuePairs(2, 0);
        pending.delete(0);
        completeAll(0);
        repeat (6) @(posedge clk);
        @(negedge clk);
        checkVal("curSqN", curSqN, s);
        @(posedge clk);
        drivePort(0, s, 1'b0);
        clearCmpl();
        waitDrain();

        // Trap in slot 0 while slot 1 is already done
        s = nextSqN;
        enqueuePairs(1, 0);
        pending.delete();
        @(posedge clk);
        drivePort(0, s, 1'b1);
        drivePort(1, s + 1, 1'b0);
        clearCmpl();
        waitDrain();

        // Younger ops finish early and must still be dropped by the squash
        s = nextSqN + 1;
        enqueuePairs(3, 0);
        pending.delete(1);
        completeAll(0);
        // Head op s completes on the edge before the squash is sampled
        @(posedge clk);
        drivePort(0, s, 1'b0);
        @(posedge clk);
        cmplUops[0] <= '0;
        squashAfter(s);
        // New ops reuse the squashed SqNs
        enqueuePairs(2, 0);
        completeAll(0);
        waitDrain();

        // Fill all entries up to maxSqN, then drain
        enqueuePairs(robPkg::RobSize / robPkg::Width, 0);
        @(negedge clk);
        checkVal("maxSqN", maxSqN, robPkg::SqN'(nextSqN - 1));
        completeAll(0);
        waitDrain();

        repeat (3) @(posedge clk);
        finishRun();
    end

endmodule
